/* common/fmaPkg.sv */
package fmaPkg;

	// binary64 word and its fields
	typedef logic [63:0] fp64T;
	typedef logic [10:0] expT;
	typedef logic [51:0] mantT;
	// significand with the hidden bit in front
	typedef logic [52:0] sigT;
	// exponent with room for sign and overflow
	typedef logic signed [12:0] wideExpT;
	typedef logic [105:0] prodT;
	// addend placed against the product, see fmaAlign
	typedef logic [161:0] addendT;
	typedef logic [2:0] frmT;
	// {invalid, divByZero, overflow, underflow, inexact}
	typedef logic [4:0] flagsT;

	localparam int mulSteps = 27;
	localparam int expMax = 2047;
	localparam int bias = 1023;

	// RISC-V frm encodings
	localparam frmT rndNearEven = 3'd0;
	localparam frmT rndZero = 3'd1;
	localparam frmT rndDown = 3'd2;
	localparam frmT rndUp = 3'd3;
	localparam frmT rndNearMax = 3'd4;

	typedef enum logic [1:0] {
		IDLE,
		MUL,
		ALIGN,
		ROUND
	} fmaStateT;

	typedef struct packed {
		logic xZero, yZero, zZero;
		logic xInf, yInf, zInf;
		logic xNaN, yNaN, zNaN;
	} opClassT;

	typedef struct packed {
		fp64T x;
		fp64T y;
		fp64T z;
		frmT frm;
		// negates Z, set for FMSUB and FNMSUB
		logic negProd;
		// negates the final result, set for FNMADD and FNMSUB
		logic negResult;
	} fmaReqT;

	typedef struct packed {
		wideExpT prodExp;
		addendT addend;
		logic addendSticky;
		logic killProd;
		opClassT opClass;
	} alignedT;

endpackage

/* rtl/fmaControl.sv */
`timescale 1ns/1ps

module fmaControl (
	input logic clk,
	input logic reset,
	input logic start,
	output logic capture,
	output logic mulStep,
	output logic alignEn,
	output logic roundEn,
	output logic busy,
	output logic done
);

	fmaPkg::fmaStateT state;
	logic [4:0] stepCnt;
	logic lastStep;

	// start only counts while idle
	assign capture = (state == fmaPkg::IDLE) && start;
	assign mulStep = (state == fmaPkg::MUL);
	assign alignEn = (state == fmaPkg::ALIGN);
	assign roundEn = (state == fmaPkg::ROUND);
	assign busy = (state != fmaPkg::IDLE);

	assign lastStep = (stepCnt == 5'(fmaPkg::mulSteps - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fmaPkg::IDLE;
			stepCnt <= '0;
			done <= 1'b0;
		end else begin
			// done trails the result register load by one cycle
			done <= roundEn;
			case (state)
				fmaPkg::IDLE: begin
					stepCnt <= '0;
					if (start) begin
						state <= fmaPkg::MUL;
					end
				end
				fmaPkg::MUL: begin
					stepCnt <= stepCnt + 5'd1;
					if (lastStep) begin
						state <= fmaPkg::ALIGN;
					end
				end
				fmaPkg::ALIGN: begin
					state <= fmaPkg::ROUND;
				end
				fmaPkg::ROUND: begin
					state <= fmaPkg::IDLE;
				end
				default: begin
					state <= fmaPkg::IDLE;
				end
			endcase
		end
	end

endmodule

/* fmaMul/fmaMantMul.sv */
`timescale 1ns/1ps

module fmaMantMul (
	input logic clk,
	input logic reset,
	input logic load,
	input logic step,
	input fmaPkg::sigT a,
	input fmaPkg::sigT b,
	output fmaPkg::prodT prod
);

	fmaPkg::prodT acc;
	// multiplicand already moved up to the weight of the current digit
	fmaPkg::prodT aShift;
	fmaPkg::sigT bRem;
	fmaPkg::prodT partial;

	// radix-4 digit picks 0, 1, 2 or 3 times the multiplicand
	always_comb begin
		case (bRem[1:0])
			2'd0: partial = '0;
			2'd1: partial = aShift;
			2'd2: partial = aShift << 1;
			default: partial = aShift + (aShift << 1);
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
			aShift <= '0;
			bRem <= '0;
		end else if (load) begin
			acc <= '0;
			aShift <= {53'b0, a};
			bRem <= b;
		end else if (step) begin
			acc <= acc + partial;
			// next digit weighs four times as much
			aShift <= aShift << 2;
			bRem <= bRem >> 2;
		end
	end

	// valid once all digits of b have been consumed
	assign prod = acc;

endmodule

/* fmaAdd/fmaAlign.sv */
`timescale 1ns/1ps

module fmaAlign (
	input logic clk,
	input logic reset,
	input logic en,
	input fmaPkg::fmaReqT req,
	input fmaPkg::prodT prod,
	output fmaPkg::sigT sigX,
	output fmaPkg::sigT sigY,
	output fmaPkg::alignedT aligned
);

	fmaPkg::expT xExp, yExp, zExp;
	fmaPkg::mantT xMan, yMan, zMan;
	fmaPkg::sigT sigZ;
	fmaPkg::wideExpT xExpEff, yExpEff, zExpEff;
	fmaPkg::wideExpT prodExp, alignCnt;
	fmaPkg::opClassT opClass;
	logic prodZero;
	logic [213:0] zPre, zShift;
	logic [7:0] shAmt;
	logic addendSticky, killProd;

	assign xExp = req.x[62:52];
	assign yExp = req.y[62:52];
	assign zExp = req.z[62:52];
	assign xMan = req.x[51:0];
	assign yMan = req.y[51:0];
	assign zMan = req.z[51:0];

	// hidden bit is zero for subnormals
	assign sigX = {xExp != '0, xMan};
	assign sigY = {yExp != '0, yMan};
	assign sigZ = {zExp != '0, zMan};

	// subnormals live at exponent 1
	assign xExpEff = (xExp == '0) ? 13'sd1 : fmaPkg::wideExpT'({2'b0, xExp});
	assign yExpEff = (yExp == '0) ? 13'sd1 : fmaPkg::wideExpT'({2'b0, yExp});
	assign zExpEff = (zExp == '0) ? 13'sd1 : fmaPkg::wideExpT'({2'b0, zExp});

	always_comb begin
		opClass.xZero = (xExp == '0) && (xMan == '0);
		opClass.yZero = (yExp == '0) && (yMan == '0);
		opClass.zZero = (zExp == '0) && (zMan == '0);
		opClass.xInf = (xExp == fmaPkg::expT'(fmaPkg::expMax)) && (xMan == '0);
		opClass.yInf = (yExp == fmaPkg::expT'(fmaPkg::expMax)) && (yMan == '0);
		opClass.zInf = (zExp == fmaPkg::expT'(fmaPkg::expMax)) && (zMan == '0);
		opClass.xNaN = (xExp == fmaPkg::expT'(fmaPkg::expMax)) && (xMan != '0);
		opClass.yNaN = (yExp == fmaPkg::expT'(fmaPkg::expMax)) && (yMan != '0);
		opClass.zNaN = (zExp == fmaPkg::expT'(fmaPkg::expMax)) && (zMan != '0);
	end

	assign prodZero = opClass.xZero | opClass.yZero;

	// a zero product is pinned to exponent 0 so Z is never shifted into sticky
	assign prodExp = prodZero ? '0 :
		xExpEff + yExpEff - fmaPkg::wideExpT'(fmaPkg::bias);

	// positive count means Z sits below the product
	assign alignCnt = prodExp - zExpEff;
	assign zPre = {55'b0, sigZ, 106'b0};

	always_comb begin
		killProd = 1'b0;
		addendSticky = 1'b0;
		zShift = zPre;
		shAmt = '0;
		if (alignCnt <= -56) begin
			// product falls entirely below the lsb of Z
			killProd = ~opClass.zZero;
			addendSticky = ~prodZero & ~opClass.zZero;
		end else if (alignCnt <= 0) begin
			shAmt = 8'(-alignCnt);
			zShift = zPre << shAmt;
		end else if (alignCnt <= 106) begin
			shAmt = 8'(alignCnt);
			zShift = zPre >> shAmt;
			// bits dropped below the 162-bit window
			addendSticky = |zShift[51:0];
		end else begin
			zShift = '0;
			addendSticky = ~opClass.zZero;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			aligned <= '0;
		end else if (en) begin
			// a killed product leaves Z unshifted, so Z's exponent heads the sum
			aligned.prodExp <= killProd ? zExpEff : prodExp;
			aligned.addend <= zShift[213:52];
			aligned.addendSticky <= addendSticky;
			aligned.killProd <= killProd;
			aligned.opClass <= opClass;
		end
	end

endmodule

/* fmaAdd/fmaAddRound.sv */
`timescale 1ns/1ps

module fmaAddRound (
	input logic clk,
	input logic reset,
	input logic en,
	input fmaPkg::fmaReqT req,
	input fmaPkg::alignedT aligned,
	input fmaPkg::prodT prod,
	output fmaPkg::fp64T result,
	output fmaPkg::flagsT flags
);

	logic xSgn, ySgn, zSgn, pSgn, zEffSgn;
	logic invZ, negSum, sumZero, wSgn, zeroSgn;
	fmaPkg::prodT prodMasked;
	logic [162:0] addendIn, sumRaw, sumNeg;
	logic [161:0] sumAbs, normTmp;
	logic [7:0] msbPos, lzCnt, shiftAmt;
	fmaPkg::wideExpT expNorm, denormShift, sumExp;
	logic denorm, flush;
	logic [53:0] normSum;
	logic normSticky, sticky, below, exactBelow;
	logic guardBit, roundBit, lsbBit, inexact;
	fmaPkg::frmT frmEff;
	logic plus1, minus1;
	logic [64:0] rounded;
	logic overflow, underflow, invalid, snan, special, nanOut;
	fmaPkg::fp64T ovfRes, resTmp;

	assign xSgn = req.x[63];
	assign ySgn = req.y[63];
	assign zSgn = req.z[63];
	assign pSgn = xSgn ^ ySgn;
	// sign Z actually enters the sum with
	assign zEffSgn = zSgn ^ req.negProd;
	assign invZ = pSgn ^ zEffSgn;

	// a final negation swaps the directed modes
	always_comb begin
		frmEff = req.frm;
		if (req.negResult && req.frm == fmaPkg::rndDown) begin
			frmEff = fmaPkg::rndUp;
		end else if (req.negResult && req.frm == fmaPkg::rndUp) begin
			frmEff = fmaPkg::rndDown;
		end
	end

	// product sits at bits 107:2, two spare bits below for guard and round
	assign prodMasked = aligned.killProd ? '0 : prod;
	assign addendIn = invZ ? ~{1'b0, aligned.addend} : {1'b0, aligned.addend};
	assign sumRaw = addendIn + {55'b0, prodMasked, 2'b0} + 163'(invZ);
	assign negSum = sumRaw[162];
	assign sumNeg = -sumRaw;
	assign sumAbs = negSum ? sumNeg[161:0] : sumRaw[161:0];
	assign sumZero = (sumAbs == '0);

	// leading one search
	always_comb begin
		msbPos = '0;
		for (int i = 0; i < 162; i++) begin
			if (sumAbs[i]) begin
				msbPos = 8'(i);
			end
		end
	end
	assign lzCnt = 8'd161 - msbPos;

	// bit 106 of the sum carries the product exponent
	assign expNorm = aligned.prodExp + 13'sd55 - fmaPkg::wideExpT'({5'b0, lzCnt});
	// lzCnt + expNorm, the shift that lands on exponent field 0
	assign denormShift = aligned.prodExp + 13'sd55;
	assign denorm = ~sumZero && (expNorm <= 0) && (denormShift >= 0);
	// too tiny to reach even the sticky window
	assign flush = ~sumZero && (expNorm <= 0) && (denormShift < 0);

	// normal results shift the leading one out, subnormals keep it
	assign shiftAmt = denorm ? denormShift[7:0] : lzCnt + 8'd1;
	assign normTmp = sumAbs << shiftAmt;
	assign normSum = normTmp[161:108];
	assign normSticky = |normTmp[107:0];
	assign sumExp = (sumZero || denorm) ? '0 : expNorm;

	assign lsbBit = normSum[2];
	assign guardBit = normSum[1];
	assign roundBit = normSum[0];
	assign sticky = normSticky | aligned.addendSticky;
	assign inexact = guardBit | roundBit | sticky;

	// Z lost bits below the window while being subtracted, so the
	// true value is a hair under what the sum shows
	assign below = aligned.addendSticky & invZ & ~normSticky;
	assign exactBelow = below & ~guardBit & ~roundBit;

	// exact zero is +0 unless rounding down, or the product sign when signs agree
	assign zeroSgn = invZ ? (frmEff == fmaPkg::rndDown) : pSgn;
	assign wSgn = sumZero ? zeroSgn : (negSum ? zEffSgn : pSgn);

	always_comb begin
		plus1 = 1'b0;
		minus1 = 1'b0;
		case (frmEff)
			fmaPkg::rndZero: begin
				minus1 = exactBelow;
			end
			fmaPkg::rndDown: begin
				plus1 = wSgn & inexact & ~exactBelow;
				minus1 = ~wSgn & exactBelow;
			end
			fmaPkg::rndUp: begin
				plus1 = ~wSgn & inexact & ~exactBelow;
				minus1 = wSgn & exactBelow;
			end
			fmaPkg::rndNearMax: begin
				plus1 = guardBit & (roundBit | (sticky & ~below) | (~roundBit & ~sticky));
			end
			default: begin
				// ties go to the even neighbour
				plus1 = guardBit & (roundBit | (sticky & ~below) |
					(~roundBit & ~sticky & lsbBit));
			end
		endcase
	end

	// a carry out of the mantissa bumps the exponent on its own
	assign rounded = {sumExp, normSum[53:2]} + 65'(plus1) - 65'(minus1);
	assign overflow = ~rounded[64] && (rounded[64:52] >= 13'(fmaPkg::expMax));
	assign underflow = flush | (inexact & (rounded[64:52] == '0));

	// directed modes stop at the largest finite value
	always_comb begin
		case (frmEff)
			fmaPkg::rndZero: ovfRes = {wSgn, 11'h7fe, {52{1'b1}}};
			fmaPkg::rndDown: ovfRes = wSgn ? {1'b1, 11'h7ff, 52'b0} : {1'b0, 11'h7fe, {52{1'b1}}};
			fmaPkg::rndUp: ovfRes = wSgn ? {1'b1, 11'h7fe, {52{1'b1}}} : {1'b0, 11'h7ff, 52'b0};
			default: ovfRes = {wSgn, 11'h7ff, 52'b0};
		endcase
	end

	assign snan = (aligned.opClass.xNaN & ~req.x[51]) | (aligned.opClass.yNaN & ~req.y[51]) |
		(aligned.opClass.zNaN & ~req.z[51]);
	// 0 * inf, or inf - inf after the product
	assign invalid = snan |
		(aligned.opClass.xInf & aligned.opClass.yZero) |
		(aligned.opClass.yInf & aligned.opClass.xZero) |
		((aligned.opClass.xInf | aligned.opClass.yInf) & aligned.opClass.zInf & invZ);
	assign special = invalid | aligned.opClass.xNaN | aligned.opClass.yNaN |
		aligned.opClass.zNaN | aligned.opClass.xInf | aligned.opClass.yInf |
		aligned.opClass.zInf;

	// priority order, first match wins
	always_comb begin
		nanOut = 1'b1;
		if (aligned.opClass.xNaN) begin
			resTmp = {req.x[63:52], 1'b1, req.x[50:0]};
		end else if (aligned.opClass.yNaN) begin
			resTmp = {req.y[63:52], 1'b1, req.y[50:0]};
		end else if (aligned.opClass.zNaN) begin
			resTmp = {req.z[63:52], 1'b1, req.z[50:0]};
		end else if (invalid) begin
			// canonical quiet NaN
			resTmp = 64'h7ff8_0000_0000_0000;
		end else begin
			nanOut = 1'b0;
			if (aligned.opClass.xInf || aligned.opClass.yInf) begin
				resTmp = {pSgn, 11'h7ff, 52'b0};
			end else if (aligned.opClass.zInf) begin
				resTmp = {zEffSgn, 11'h7ff, 52'b0};
			end else if (overflow) begin
				resTmp = ovfRes;
			end else if (flush) begin
				resTmp = {wSgn, 63'b0};
			end else if (aligned.killProd) begin
				// Z nudged by one ulp toward the tiny product
				resTmp = {wSgn, req.z[62:0] + 63'(plus1) - 63'(minus1)};
			end else begin
				resTmp = {wSgn, rounded[62:0]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			flags <= '0;
		end else if (en) begin
			// NaNs keep their sign through FNMADD and FNMSUB
			result <= {resTmp[63] ^ (req.negResult & ~nanOut), resTmp[62:0]};
			flags <= {invalid, 1'b0, overflow & ~special, underflow & ~special,
				(inexact | overflow | flush) & ~special};
		end
	end

endmodule

/* rtl/fmaTop.sv */
`timescale 1ns/1ps

module fmaTop (
	input logic clk,
	input logic reset,
	input logic start,
	input fmaPkg::fmaReqT req,
	output logic busy,
	output logic done,
	output fmaPkg::fp64T result,
	output fmaPkg::flagsT flags
);

	logic capture, mulStep, alignEn, roundEn;
	fmaPkg::fmaReqT reqQ, alignReq;
	fmaPkg::sigT sigX, sigY;
	fmaPkg::prodT prod;
	fmaPkg::alignedT aligned;

	// operands held for the whole operation
	always_ff @(posedge clk) begin
		if (capture) begin
			reqQ <= req;
		end
	end

	// the multiplier loads in the capture cycle, before reqQ is written
	assign alignReq = capture ? req : reqQ;

	fmaControl control (
		.clk(clk),
		.reset(reset),
		.start(start),
		.capture(capture),
		.mulStep(mulStep),
		.alignEn(alignEn),
		.roundEn(roundEn),
		.busy(busy),
		.done(done)
	);

	fmaMantMul mantMul (
		.clk(clk),
		.reset(reset),
		.load(capture),
		.step(mulStep),
		.a(sigX),
		.b(sigY),
		.prod(prod)
	);

	fmaAlign align (
		.clk(clk),
		.reset(reset),
		.en(alignEn),
		.req(alignReq),
		.prod(prod),
		.sigX(sigX),
		.sigY(sigY),
		.aligned(aligned)
	);

	fmaAddRound addRound (
		.clk(clk),
		.reset(reset),
		.en(roundEn),
		.req(reqQ),
		.aligned(aligned),
		.prod(prod),
		.result(result),
		.flags(flags)
	);

endmodule

/* sim/fmaTb_properties.sv */
`timescale 1ns/1ps

module fmaProperties (
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic done,
	input fmaPkg::flagsT flags
);

	// done lasts a single cycle
	doneOneCycle: assert property (
		@(posedge clk) disable iff (reset) done |=> !done
	) else $error("done high for more than one cycle");

	// result loads at edge 29 after the capture edge
	// so done is first seen high at the following edge
	doneLatency: assert property (
		@(posedge clk) disable iff (reset) (start && !busy) |-> ##29 !done ##1 done
	) else $error("done not 29 cycles after an accepted start");

	resetIdle: assert property (
		@(posedge clk) reset |=> (!busy && !done)
	) else $error("busy or done high right after reset");

	// FMA never divides
	noDivByZero: assert property (
		@(posedge clk) disable iff (reset) !flags[3]
	) else $error("divByZero flag set");

endmodule

bind fmaTop fmaProperties props (
	.clk(clk),
	.reset(reset),
	.start(start),
	.busy(busy),
	.done(done),
	.flags(flags)
);

/* sim/fmaTb.sv */
`timescale 1ns/1ps

module fmaTb;

	// one table entry holds the request and what the DUT must answer
	typedef struct packed {
		fmaPkg::fmaReqT req;
		fmaPkg::fp64T expRes;
		fmaPkg::flagsT expFlags;
	} rowT;

	logic clk;
	logic reset;
	logic start;
	fmaPkg::fmaReqT req;
	logic busy;
	logic done;
	fmaPkg::fp64T result;
	fmaPkg::flagsT flags;

	rowT rows[$];
	string rowNames[$];
	logic [31:0] lfsrState;
	int testCount;
	int passCount;
	int failCount;
	logic stopRun;

	fmaTop uut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.req(req),
		.busy(busy),
		.done(done),
		.result(result),
		.flags(flags)
	);

	initial begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one LFSR step per bit taken
	function automatic int drawBits(input int n);
		int val;
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			val = (val << 1) | int'(lfsrState[0]);
		end
		return val;
	endfunction

	function automatic fmaPkg::fmaReqT makeReq(input fmaPkg::fp64T x, input fmaPkg::fp64T y,
		input fmaPkg::fp64T z, input fmaPkg::frmT frm, input logic negProd,
		input logic negResult);
		fmaPkg::fmaReqT r;
		r.x = x;
		r.y = y;
		r.z = z;
		r.frm = frm;
		r.negProd = negProd;
		r.negResult = negResult;
		return r;
	endfunction

	task automatic addRow(input string name, input fmaPkg::fp64T x, input fmaPkg::fp64T y,
		input fmaPkg::fp64T z, input fmaPkg::frmT frm, input logic negProd,
		input logic negResult, input fmaPkg::fp64T expRes, input fmaPkg::flagsT expFlags);
		rowT row;
		row.req = makeReq(x, y, z, frm, negProd, negResult);
		row.expRes = expRes;
		row.expFlags = expFlags;
		rows.push_back(row);
		rowNames.push_back(name);
	endtask

	// called on a falling edge, returns on the falling edge where done is seen
	task automatic runOp(input fmaPkg::fmaReqT r, input int extraAt,
		input fmaPkg::fmaReqT extraReq, output int latency, output logic timedOut,
		output logic busyBad);
		int cnt;
		latency = 0;
		timedOut = 1'b1;
		busyBad = 1'b0;
		req = r;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		cnt = 1;
		while (timedOut && cnt <= 100) begin
			if (done) begin
				timedOut = 1'b0;
				latency = cnt - 1;
			end else begin
				// busy covers every cycle between the start edge and done
				if (busy !== 1'b1) begin
					$display("CHECK FAILED at %0t: busy expected 1 actual %b", $time, busy);
					busyBad = 1'b1;
				end
				if (cnt == extraAt) begin
					// DUT is busy here so this start must be dropped
					req = extraReq;
					start = 1'b1;
				end else begin
					start = 1'b0;
				end
				@(negedge clk);
				cnt++;
			end
		end
		start = 1'b0;
	endtask

	task automatic checkOutcome(input string name, input fmaPkg::fp64T expRes,
		input fmaPkg::flagsT expFlags, input int latency, input logic timedOut,
		input logic busyBad);
		logic ok;
		ok = 1'b1;
		testCount++;
		if (timedOut) begin
			$display("%s: done did not arrive within 100 cycles", name);
			ok = 1'b0;
			stopRun = 1'b1;
		end else begin
			if (busyBad) begin
				ok = 1'b0;
			end
			if (result !== expRes) begin
				$display("CHECK FAILED at %0t: result expected %h actual %h",
					$time, expRes, result);
				ok = 1'b0;
			end
			if (flags !== expFlags) begin
				$display("CHECK FAILED at %0t: flags expected %b actual %b",
					$time, expFlags, flags);
				ok = 1'b0;
			end
			if (latency != 29) begin
				$display("CHECK FAILED at %0t: latency expected 29 actual %0d", $time, latency);
				ok = 1'b0;
			end
			if (busy !== 1'b0) begin
				$display("CHECK FAILED at %0t: busy expected 0 actual %b", $time, busy);
				ok = 1'b0;
			end
			@(negedge clk);
			if (done !== 1'b0) begin
				$display("CHECK FAILED at %0t: done expected 0 actual %b", $time, done);
				ok = 1'b0;
			end
		end
		if (ok) begin
			passCount++;
			$display("%s: ok", name);
		end else begin
			failCount++;
			$display("%s: failed", name);
		end
	endtask

	// columns: name, x, y, z, frm, negProd, negResult, expected result, expected flags
	task automatic buildTable();
		addRow("fmadd 2*3+1", 64'h4000000000000000, 64'h4008000000000000,
			64'h3ff0000000000000, 3'd0, 0, 0, 64'h401c000000000000, 5'b00000);
		addRow("fmsub 2*3-1", 64'h4000000000000000, 64'h4008000000000000,
			64'h3ff0000000000000, 3'd0, 1, 0, 64'h4014000000000000, 5'b00000);
		addRow("fnmadd -2*3-1", 64'h4000000000000000, 64'h4008000000000000,
			64'h3ff0000000000000, 3'd0, 0, 1, 64'hc01c000000000000, 5'b00000);
		addRow("fnmsub -2*3+1", 64'h4000000000000000, 64'h4008000000000000,
			64'h3ff0000000000000, 3'd0, 1, 1, 64'hc014000000000000, 5'b00000);
		// product is 1.5 plus 4.5 ulp, an exact tie on an even lsb
		addRow("tie rne", 64'h3ff0000000000003, 64'h3ff8000000000000,
			64'h0000000000000000, 3'd0, 0, 0, 64'h3ff8000000000004, 5'b00001);
		addRow("tie rtz", 64'h3ff0000000000003, 64'h3ff8000000000000,
			64'h0000000000000000, 3'd1, 0, 0, 64'h3ff8000000000004, 5'b00001);
		addRow("tie rdn", 64'h3ff0000000000003, 64'h3ff8000000000000,
			64'h0000000000000000, 3'd2, 0, 0, 64'h3ff8000000000004, 5'b00001);
		addRow("tie rup", 64'h3ff0000000000003, 64'h3ff8000000000000,
			64'h0000000000000000, 3'd3, 0, 0, 64'h3ff8000000000005, 5'b00001);
		addRow("tie rmm", 64'h3ff0000000000003, 64'h3ff8000000000000,
			64'h0000000000000000, 3'd4, 0, 0, 64'h3ff8000000000005, 5'b00001);
		addRow("fnmadd tie rdn", 64'h3ff0000000000003, 64'h3ff8000000000000,
			64'h0000000000000000, 3'd2, 0, 1, 64'hbff8000000000005, 5'b00001);
		addRow("qnan y first", 64'h3ff0000000000000, 64'h7ff8000000000abc,
			64'h7ff8000000000def, 3'd0, 0, 0, 64'h7ff8000000000abc, 5'b00000);
		addRow("snan x quieted", 64'h7ff0000000000042, 64'h3ff0000000000000,
			64'h7ff8000000000def, 3'd0, 0, 0, 64'h7ff8000000000042, 5'b10000);
		addRow("zero times inf", 64'h0000000000000000, 64'h7ff0000000000000,
			64'h3ff0000000000000, 3'd0, 0, 0, 64'h7ff8000000000000, 5'b10000);
		addRow("inf minus inf", 64'h7ff0000000000000, 64'h3ff0000000000000,
			64'h7ff0000000000000, 3'd0, 1, 0, 64'h7ff8000000000000, 5'b10000);
		addRow("minus inf product", 64'hfff0000000000000, 64'h4000000000000000,
			64'h3ff0000000000000, 3'd0, 0, 0, 64'hfff0000000000000, 5'b00000);
		addRow("minus inf addend", 64'h3ff0000000000000, 64'h3ff0000000000000,
			64'h7ff0000000000000, 3'd0, 1, 0, 64'hfff0000000000000, 5'b00000);
		addRow("overflow rne", 64'h7fefffffffffffff, 64'h4000000000000000,
			64'h0000000000000000, 3'd0, 0, 0, 64'h7ff0000000000000, 5'b00101);
		addRow("overflow rtz", 64'h7fefffffffffffff, 64'h4000000000000000,
			64'h0000000000000000, 3'd1, 0, 0, 64'h7fefffffffffffff, 5'b00101);
		addRow("neg overflow rmm", 64'hffefffffffffffff, 64'h4000000000000000,
			64'h0000000000000000, 3'd4, 0, 0, 64'hfff0000000000000, 5'b00101);
		// 2^-1200 against 1.0
		addRow("tiny plus one rup", 64'h1a70000000000000, 64'h1a70000000000000,
			64'h3ff0000000000000, 3'd3, 0, 0, 64'h3ff0000000000001, 5'b00001);
		addRow("tiny minus one rup", 64'h1a70000000000000, 64'h1a70000000000000,
			64'h3ff0000000000000, 3'd3, 1, 0, 64'hbfefffffffffffff, 5'b00001);
		addRow("tiny plus one rdn", 64'h1a70000000000000, 64'h1a70000000000000,
			64'h3ff0000000000000, 3'd2, 0, 0, 64'h3ff0000000000000, 5'b00001);
		// 2^-1000 times 2^-60 is an exact subnormal
		addRow("exact subnormal", 64'h0170000000000000, 64'h3c30000000000000,
			64'h0000000000000000, 3'd0, 0, 0, 64'h0000000000004000, 5'b00000);
		addRow("cancel rne", 64'h4008000000000000, 64'h4014000000000000,
			64'h402e000000000000, 3'd0, 1, 0, 64'h0000000000000000, 5'b00000);
		addRow("cancel rtz", 64'h4008000000000000, 64'h4014000000000000,
			64'h402e000000000000, 3'd1, 1, 0, 64'h0000000000000000, 5'b00000);
		addRow("cancel rup", 64'h4008000000000000, 64'h4014000000000000,
			64'h402e000000000000, 3'd3, 1, 0, 64'h0000000000000000, 5'b00000);
		addRow("cancel rmm", 64'h4008000000000000, 64'h4014000000000000,
			64'h402e000000000000, 3'd4, 1, 0, 64'h0000000000000000, 5'b00000);
		addRow("cancel rdn", 64'h4008000000000000, 64'h4014000000000000,
			64'h402e000000000000, 3'd2, 1, 0, 64'h8000000000000000, 5'b00000);
	endtask

	initial begin
		int latency;
		logic timedOut;
		logic busyBad;
		logic holdOk;
		longint xi, yi, zi, expInt;
		int op;
		fmaPkg::fmaReqT r;
		fmaPkg::fmaReqT idleReq;

		reset = 1'b1;
		start = 1'b0;
		req = '0;
		idleReq = '0;
		lfsrState = 32'h2ba930b0;
		testCount = 0;
		passCount = 0;
		failCount = 0;
		stopRun = 1'b0;
		buildTable();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// state straight out of reset
		testCount++;
		if (busy !== 1'b0 || done !== 1'b0 || result !== '0 || flags !== '0) begin
			$display("CHECK FAILED at %0t: busy/done/result/flags expected 0 actual %b/%b/%h/%b",
				$time, busy, done, result, flags);
			failCount++;
			$display("reset state: failed");
		end else begin
			passCount++;
			$display("reset state: ok");
		end

		for (int i = 0; i < rows.size() && !stopRun; i++) begin
			runOp(rows[i].req, 0, idleReq, latency, timedOut, busyBad);
			checkOutcome(rowNames[i], rows[i].expRes, rows[i].expFlags, latency, timedOut,
				busyBad);
		end

		// second start five cycles in must not disturb the first operation
		if (!stopRun) begin
			r = makeReq(64'h4000000000000000, 64'h4008000000000000, 64'h3ff0000000000000,
				3'd0, 0, 0);
			runOp(r, 5, makeReq(64'h4059000000000000, 64'h3ff0000000000000, '0, 3'd0, 0, 0),
				latency, timedOut, busyBad);
			checkOutcome("start while busy", 64'h401c000000000000, 5'b00000, latency, timedOut,
				busyBad);
		end
		if (!stopRun) begin
			holdOk = 1'b1;
			testCount++;
			for (int k = 0; k < 40; k++) begin
				@(negedge clk);
				if (done !== 1'b0) begin
					$display("CHECK FAILED at %0t: done expected 0 actual %b", $time, done);
					holdOk = 1'b0;
				end
				if (result !== 64'h401c000000000000) begin
					$display("CHECK FAILED at %0t: result expected %h actual %h",
						$time, 64'h401c000000000000, result);
					holdOk = 1'b0;
				end
			end
			if (holdOk) begin
				passCount++;
				$display("held result: ok");
			end else begin
				failCount++;
				$display("held result: failed");
			end
		end

		// small signed integers, every sum below 2^25 is exact
		for (int i = 0; i < 16 && !stopRun; i++) begin
			xi = drawBits(12);
			yi = drawBits(12);
			zi = drawBits(12);
			if (drawBits(1) == 1) begin
				xi = -xi;
			end
			if (drawBits(1) == 1) begin
				zi = -zi;
			end
			// keep exact cancellation out of the random set
			if (xi * yi == zi || xi * yi == -zi) begin
				zi = zi + 1;
			end
			op = drawBits(2);
			case (op)
				0: expInt = xi * yi + zi;
				1: expInt = xi * yi - zi;
				2: expInt = -(xi * yi) - zi;
				default: expInt = -(xi * yi) + zi;
			endcase
			r = makeReq($realtobits(real'(xi)), $realtobits(real'(yi)),
				$realtobits(real'(zi)), 3'd0, op[0], op[1]);
			runOp(r, 0, idleReq, latency, timedOut, busyBad);
			checkOutcome($sformatf("random %0d op %0d", i, op), $realtobits(real'(expInt)),
				5'b00000, latency, timedOut, busyBad);
		end

		$display("%0d tests, %0d passed, %0d failed", testCount, passCount, failCount);
		if (failCount == 0 && !stopRun) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* verilog.f */
common/fmaPkg.sv
rtl/fmaControl.sv
fmaMul/fmaMantMul.sv
fmaAdd/fmaAlign.sv
fmaAdd/fmaAddRound.sv
rtl/fmaTop.sv
sim/fmaTb_properties.sv
sim/fmaTb.sv

/* Bender.yml */
package:
  name: fma

sources:
  - files:
      - common/fmaPkg.sv
      - rtl/fmaControl.sv
      - fmaMul/fmaMantMul.sv
      - fmaAdd/fmaAlign.sv
      - fmaAdd/fmaAddRound.sv
      - rtl/fmaTop.sv
  - target: simulation
    files:
      - sim/fmaTb_properties.sv
      - sim/fmaTb.sv
